// ==== mipsAluPkg.sv ====
`default_nettype none

package mipsAluPkg;

    localparam int dataW = 32;

    // ########################################
    // primary opcodes
    localparam logic [5:0] opcodeR     = 6'h00;
    localparam logic [5:0] opcodeAddiu = 6'h09;
    localparam logic [5:0] opcodeSlti  = 6'h0a;
    localparam logic [5:0] opcodeSltiu = 6'h0b;
    localparam logic [5:0] opcodeAndi  = 6'h0c;
    localparam logic [5:0] opcodeOri   = 6'h0d;
    localparam logic [5:0] opcodeXori  = 6'h0e;

    // ########################################
    // function codes, R-type only
    localparam logic [5:0] functSll   = 6'h00;
    localparam logic [5:0] functSrl   = 6'h02;
    localparam logic [5:0] functSra   = 6'h03;
    localparam logic [5:0] functSllv  = 6'h04;
    localparam logic [5:0] functSrlv  = 6'h06;
    localparam logic [5:0] functSrav  = 6'h07;
    localparam logic [5:0] functMfhi  = 6'h10;
    localparam logic [5:0] functMflo  = 6'h12;
    localparam logic [5:0] functMult  = 6'h18;
    localparam logic [5:0] functMultu = 6'h19;
    localparam logic [5:0] functDiv   = 6'h1a;
    localparam logic [5:0] functDivu  = 6'h1b;
    localparam logic [5:0] functAddu  = 6'h21;
    localparam logic [5:0] functSubu  = 6'h23;
    localparam logic [5:0] functAnd   = 6'h24;
    localparam logic [5:0] functOr    = 6'h25;
    localparam logic [5:0] functXor   = 6'h26;
    localparam logic [5:0] functSlt   = 6'h2a;
    localparam logic [5:0] functSltu  = 6'h2b;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

    // I-type ops reuse the R-type names, operandB carries the immediate
    typedef enum logic [4:0] {
        opNone, opAddu, opSubu, opAnd, opOr, opXor, opSlt, opSltu,
        opSll, opSrl, opSra, opSllv, opSrlv, opSrav,
        opMult, opMultu, opDiv, opDivu, opMfhi, opMflo
    } aluOpT;

    typedef struct packed {
        aluOpT            op;
        logic [dataW-1:0] operandB;
        logic [4:0]       shamt;
        logic             illegal;
    } decodedT;

    typedef struct packed {
        logic             valid;
        logic             illegal;
        logic [dataW-1:0] data;
    } execResultT;

    typedef struct packed {
        logic [dataW-1:0] hi;
        logic [dataW-1:0] lo;
    } hiLoT;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`default_nettype none
`timescale 1ns/1ns

module instrDecoder (
    input  mipsAluPkg::instrT                instr,
    input  logic [mipsAluPkg::dataW-1:0]     rtData,
    output mipsAluPkg::decodedT              decoded
);

    logic [mipsAluPkg::dataW-1:0] immSext;
    logic [mipsAluPkg::dataW-1:0] immZext;

    assign immSext = {{(mipsAluPkg::dataW-16){instr.i.imm[15]}}, instr.i.imm};
    assign immZext = {{(mipsAluPkg::dataW-16){1'b0}}, instr.i.imm};

    always_comb begin
        decoded.op       = mipsAluPkg::opNone;
        decoded.operandB = rtData;
        decoded.shamt    = instr.r.shamt;
        decoded.illegal  = 1'b0;

        case (instr.r.opcode)
            mipsAluPkg::opcodeR: begin
                case (instr.r.funct)
                    mipsAluPkg::functAddu:  decoded.op = mipsAluPkg::opAddu;
                    mipsAluPkg::functSubu:  decoded.op = mipsAluPkg::opSubu;
                    mipsAluPkg::functAnd:   decoded.op = mipsAluPkg::opAnd;
                    mipsAluPkg::functOr:    decoded.op = mipsAluPkg::opOr;
                    mipsAluPkg::functXor:   decoded.op = mipsAluPkg::opXor;
                    mipsAluPkg::functSlt:   decoded.op = mipsAluPkg::opSlt;
                    mipsAluPkg::functSltu:  decoded.op = mipsAluPkg::opSltu;
                    mipsAluPkg::functSll:   decoded.op = mipsAluPkg::opSll;
                    mipsAluPkg::functSrl:   decoded.op = mipsAluPkg::opSrl;
                    mipsAluPkg::functSra:   decoded.op = mipsAluPkg::opSra;
                    mipsAluPkg::functSllv:  decoded.op = mipsAluPkg::opSllv;
                    mipsAluPkg::functSrlv:  decoded.op = mipsAluPkg::opSrlv;
                    mipsAluPkg::functSrav:  decoded.op = mipsAluPkg::opSrav;
                    mipsAluPkg::functMult:  decoded.op = mipsAluPkg::opMult;
                    mipsAluPkg::functMultu: decoded.op = mipsAluPkg::opMultu;
                    mipsAluPkg::functDiv:   decoded.op = mipsAluPkg::opDiv;
                    mipsAluPkg::functDivu:  decoded.op = mipsAluPkg::opDivu;
                    mipsAluPkg::functMfhi:  decoded.op = mipsAluPkg::opMfhi;
                    mipsAluPkg::functMflo:  decoded.op = mipsAluPkg::opMflo;
                    default:                decoded.illegal = 1'b1;
                endcase
            end
            mipsAluPkg::opcodeAddiu: begin
                decoded.op       = mipsAluPkg::opAddu; // no overflow trap
                decoded.operandB = immSext;
            end
            mipsAluPkg::opcodeSlti: begin
                decoded.op       = mipsAluPkg::opSlt;
                decoded.operandB = immSext;
            end
            mipsAluPkg::opcodeSltiu: begin
                decoded.op       = mipsAluPkg::opSltu; // sign-extended, then unsigned compare
                decoded.operandB = immSext;
            end
            mipsAluPkg::opcodeAndi: begin
                decoded.op       = mipsAluPkg::opAnd;
                decoded.operandB = immZext;
            end
            mipsAluPkg::opcodeOri: begin
                decoded.op       = mipsAluPkg::opOr;
                decoded.operandB = immZext;
            end
            mipsAluPkg::opcodeXori: begin
                decoded.op       = mipsAluPkg::opXor;
                decoded.operandB = immZext;
            end
            default: begin
                decoded.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== intAlu.sv ====
`default_nettype none
`timescale 1ns/1ns

module intAlu (
    input  mipsAluPkg::decodedT              decoded,
    input  logic [mipsAluPkg::dataW-1:0]     rsData,
    output logic [mipsAluPkg::dataW-1:0]     aluData
);

    logic [mipsAluPkg::dataW-1:0] opB;
    logic [4:0]                   varAmt;
    logic                         ltSigned;
    logic                         ltUnsigned;

    assign opB    = decoded.operandB;
    assign varAmt = rsData[4:0]; // only the low 5 bits of rs count

    assign ltSigned   = $signed(rsData) < $signed(opB);
    assign ltUnsigned = rsData < opB;

    // ########################################
    // single-word results
    always_comb begin
        aluData = '0;
        case (decoded.op)
            mipsAluPkg::opAddu: aluData = rsData + opB;
            mipsAluPkg::opSubu: aluData = rsData - opB;
            mipsAluPkg::opAnd:  aluData = rsData & opB;
            mipsAluPkg::opOr:   aluData = rsData | opB;
            mipsAluPkg::opXor:  aluData = rsData ^ opB;

            mipsAluPkg::opSlt: begin
                aluData = {{(mipsAluPkg::dataW-1){1'b0}}, ltSigned};
            end
            mipsAluPkg::opSltu: begin
                aluData = {{(mipsAluPkg::dataW-1){1'b0}}, ltUnsigned};
            end

            // shifts act on rt, held in operandB
            mipsAluPkg::opSll:  aluData = opB << decoded.shamt;
            mipsAluPkg::opSrl:  aluData = opB >> decoded.shamt;
            mipsAluPkg::opSra:  aluData = $signed(opB) >>> decoded.shamt;
            mipsAluPkg::opSllv: aluData = opB << varAmt;
            mipsAluPkg::opSrlv: aluData = opB >> varAmt;
            mipsAluPkg::opSrav: aluData = $signed(opB) >>> varAmt;

            default: aluData = '0; // mul/div, mfhi/mflo and illegal
        endcase
    end

endmodule

`default_nettype wire

// ==== mulDivUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

module mulDivUnit (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             start,
    input  mipsAluPkg::decodedT              decoded,
    input  logic [mipsAluPkg::dataW-1:0]     rsData,
    input  logic [mipsAluPkg::dataW-1:0]     rtData,
    output mipsAluPkg::hiLoT                 hiLo
);

    logic signed [2*mipsAluPkg::dataW-1:0] prodSigned;
    logic        [2*mipsAluPkg::dataW-1:0] prodUnsigned;

    logic [mipsAluPkg::dataW-1:0] rsMag;
    logic [mipsAluPkg::dataW-1:0] rtMag;
    logic [mipsAluPkg::dataW-1:0] quotMag;
    logic [mipsAluPkg::dataW-1:0] remMag;
    logic [mipsAluPkg::dataW-1:0] quotSigned;
    logic [mipsAluPkg::dataW-1:0] remSigned;
    logic                         divByZero;

    assign prodSigned   = $signed(rsData) * $signed(rtData);
    assign prodUnsigned = {{mipsAluPkg::dataW{1'b0}}, rsData} * {{mipsAluPkg::dataW{1'b0}}, rtData};

    // ########################################
    // signed divide via magnitudes
    assign rsMag   = rsData[mipsAluPkg::dataW-1] ? -rsData : rsData;
    assign rtMag   = rtData[mipsAluPkg::dataW-1] ? -rtData : rtData;
    assign quotMag = divByZero ? '0 : rsMag / rtMag;
    assign remMag  = divByZero ? '0 : rsMag % rtMag;

    // quotient truncates toward zero, remainder follows the dividend
    assign quotSigned = (rsData[mipsAluPkg::dataW-1] ^ rtData[mipsAluPkg::dataW-1]) ?
                        -quotMag : quotMag;
    assign remSigned  = rsData[mipsAluPkg::dataW-1] ? -remMag : remMag;

    assign divByZero = (rtData == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hiLo <= '0;
        end else if (start) begin
            case (decoded.op)
                mipsAluPkg::opMult:  {hiLo.hi, hiLo.lo} <= prodSigned;
                mipsAluPkg::opMultu: {hiLo.hi, hiLo.lo} <= prodUnsigned;
                mipsAluPkg::opDiv: begin
                    if (!divByZero) begin
                        hiLo.hi <= remSigned;
                        hiLo.lo <= quotSigned;
                    end
                end
                mipsAluPkg::opDivu: begin
                    if (!divByZero) begin
                        hiLo.hi <= rsData % rtData;
                        hiLo.lo <= rsData / rtData;
                    end
                end
                default: ; // hi/lo hold
            endcase
        end
    end

    hiLoHoldCheck: assert property (@(posedge clk) disable iff (!rstN)
        !start |=> $stable(hiLo))
        else $error("hi/lo changed with no instruction in flight");

endmodule

`default_nettype wire

// ==== mipsExecute.sv ====
`default_nettype none
`timescale 1ns/1ns

module mipsExecute (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             issue,
    input  mipsAluPkg::instrT                instr,
    input  logic [mipsAluPkg::dataW-1:0]     rsData,
    input  logic [mipsAluPkg::dataW-1:0]     rtData,
    output mipsAluPkg::execResultT           result,
    output mipsAluPkg::hiLoT                 hiLo
);

    logic                         issueQ;
    mipsAluPkg::instrT            instrQ;
    logic [mipsAluPkg::dataW-1:0] rsQ;
    logic [mipsAluPkg::dataW-1:0] rtQ;

    mipsAluPkg::decodedT          decoded;
    logic [mipsAluPkg::dataW-1:0] aluData;
    logic [mipsAluPkg::dataW-1:0] stageData;

    // ########################################
    // stage 0 capture
    always_ff @(posedge clk) begin
        instrQ <= instr;
        rsQ    <= rsData;
        rtQ    <= rtData;
        if (!rstN) begin
            issueQ <= 1'b0;
        end else begin
            issueQ <= issue;
        end
    end

    instrDecoder decoder (.instr(instrQ), .rtData(rtQ), .decoded(decoded));

    intAlu alu (.decoded(decoded), .rsData(rsQ), .aluData(aluData));

    mulDivUnit mulDiv (
        .clk(clk), .rstN(rstN), .start(issueQ), .decoded(decoded),
        .rsData(rsQ), .rtData(rtQ), .hiLo(hiLo)
    );

    always_comb begin
        case (decoded.op)
            mipsAluPkg::opMfhi: stageData = hiLo.hi;
            mipsAluPkg::opMflo: stageData = hiLo.lo;
            default:            stageData = aluData; // 0 for illegal
        endcase
    end

    // ########################################
    // result register
    always_ff @(posedge clk) begin
        result.data <= stageData;
        if (!rstN) begin
            result.valid   <= 1'b0;
            result.illegal <= 1'b0;
        end else begin
            result.valid   <= issueQ;
            result.illegal <= issueQ & decoded.illegal;
        end
    end

    issueToValid: assert property (@(posedge clk) disable iff (!rstN)
        issue |-> ##2 result.valid)
        else $error("no valid pulse two edges after issue");

endmodule

`default_nettype wire

// ==== mipsExecuteTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module mipsExecuteTb;

    typedef struct packed {
        mipsAluPkg::instrT      instr;
        logic [31:0]            rs;
        logic [31:0]            rt;
        mipsAluPkg::execResultT expResult;
        mipsAluPkg::hiLoT       expHiLo;
    } vectorT;

    logic                   clk;
    logic                   rstN;
    logic                   issue;
    mipsAluPkg::instrT      instr;
    logic [31:0]            rsData;
    logic [31:0]            rtData;
    mipsAluPkg::execResultT result;
    mipsAluPkg::hiLoT       hiLo;

    vectorT           vectors[$];
    mipsAluPkg::hiLoT modelHiLo; // reference hi/lo in program order
    int               errors;
    bit               tableReady;

    mipsExecute uut (
        .clk(clk), .rstN(rstN), .issue(issue), .instr(instr),
        .rsData(rsData), .rtData(rtData), .result(result), .hiLo(hiLo)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic mipsAluPkg::instrT rOp(input logic [5:0] funct, input logic [4:0] shamt);
        mipsAluPkg::instrT w;
        w = '0;
        w.r.opcode = mipsAluPkg::opcodeR;
        w.r.shamt  = shamt;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic mipsAluPkg::instrT iOp(input logic [5:0] opcode, input logic [15:0] imm);
        mipsAluPkg::instrT w;
        w = '0;
        w.i.opcode = opcode;
        w.i.imm    = imm;
        return w;
    endfunction

    // ########################################
    // reference model, one table entry per call
    task automatic addVec(input mipsAluPkg::instrT w, input logic [31:0] rs, input logic [31:0] rt);
        vectorT      v;
        logic [31:0] immS;
        logic [31:0] immZ;
        longint      a;
        longint      b;
        longint      c;
        immS = {{16{w.i.imm[15]}}, w.i.imm};
        immZ = {16'h0000, w.i.imm};
        a = $signed(rs);
        b = $signed(rt);
        c = $signed(immS);
        v.instr = w;
        v.rs = rs;
        v.rt = rt;
        v.expResult = '0;
        v.expResult.valid = 1'b1;
        case (w.r.opcode)
            mipsAluPkg::opcodeAddiu: v.expResult.data = rs + immS;
            mipsAluPkg::opcodeSlti:  v.expResult.data = {31'b0, a < c};
            mipsAluPkg::opcodeSltiu: v.expResult.data = {31'b0, rs < immS};
            mipsAluPkg::opcodeAndi:  v.expResult.data = rs & immZ;
            mipsAluPkg::opcodeOri:   v.expResult.data = rs | immZ;
            mipsAluPkg::opcodeXori:  v.expResult.data = rs ^ immZ;
            mipsAluPkg::opcodeR: begin
                case (w.r.funct)
                    mipsAluPkg::functAddu:  v.expResult.data = rs + rt;
                    mipsAluPkg::functSubu:  v.expResult.data = rs - rt;
                    mipsAluPkg::functAnd:   v.expResult.data = rs & rt;
                    mipsAluPkg::functOr:    v.expResult.data = rs | rt;
                    mipsAluPkg::functXor:   v.expResult.data = rs ^ rt;
                    mipsAluPkg::functSlt:   v.expResult.data = {31'b0, a < b};
                    mipsAluPkg::functSltu:  v.expResult.data = {31'b0, rs < rt};
                    mipsAluPkg::functSll:   v.expResult.data = rt << w.r.shamt;
                    mipsAluPkg::functSrl:   v.expResult.data = rt >> w.r.shamt;
                    mipsAluPkg::functSra:   v.expResult.data = 32'(b >>> w.r.shamt);
                    mipsAluPkg::functSllv:  v.expResult.data = rt << rs[4:0];
                    mipsAluPkg::functSrlv:  v.expResult.data = rt >> rs[4:0];
                    mipsAluPkg::functSrav:  v.expResult.data = 32'(b >>> rs[4:0]);
                    mipsAluPkg::functMult:  {modelHiLo.hi, modelHiLo.lo} = a * b;
                    mipsAluPkg::functMultu: begin
                        {modelHiLo.hi, modelHiLo.lo} = {32'h0, rs} * {32'h0, rt};
                    end
                    mipsAluPkg::functDiv: begin
                        if (rt != 32'h0) begin
                            modelHiLo.lo = 32'(a / b); // 64-bit math avoids overflow
                            modelHiLo.hi = 32'(a % b);
                        end
                    end
                    mipsAluPkg::functDivu: begin
                        if (rt != 32'h0) begin
                            modelHiLo.lo = rs / rt;
                            modelHiLo.hi = rs % rt;
                        end
                    end
                    mipsAluPkg::functMfhi:  v.expResult.data = modelHiLo.hi;
                    mipsAluPkg::functMflo:  v.expResult.data = modelHiLo.lo;
                    default:                v.expResult.illegal = 1'b1;
                endcase
            end
            default: v.expResult.illegal = 1'b1;
        endcase
        v.expHiLo = modelHiLo;
        vectors.push_back(v);
    endtask

    task automatic buildTable();
        logic [5:0] randFuncts [6] = '{mipsAluPkg::functAnd, mipsAluPkg::functOr,
            mipsAluPkg::functXor, mipsAluPkg::functSubu, mipsAluPkg::functSltu,
            mipsAluPkg::functSrav};
        int idx;
        modelHiLo = '0;
        addVec(rOp(mipsAluPkg::functAddu, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        addVec(rOp(mipsAluPkg::functSubu, 5'd0), 32'h0000_0000, 32'h0000_0001);
        addVec(rOp(mipsAluPkg::functXor, 5'd0), $urandom, $urandom);
        addVec(iOp(mipsAluPkg::opcodeAddiu, 16'hffff), 32'h0000_000a, $urandom);
        addVec(iOp(mipsAluPkg::opcodeAndi, 16'h8000), 32'hffff_ffff, $urandom);
        addVec(iOp(mipsAluPkg::opcodeOri, 16'hf0f0), 32'h1234_0000, $urandom);
        addVec(iOp(mipsAluPkg::opcodeXori, 16'hffff), 32'hffff_ffff, $urandom);
        addVec(rOp(mipsAluPkg::functSll, 5'd4), $urandom, 32'h8000_000f);
        addVec(rOp(mipsAluPkg::functSrl, 5'd31), $urandom, 32'h8000_0000);
        addVec(rOp(mipsAluPkg::functSra, 5'd4), $urandom, 32'h8000_0000);
        addVec(rOp(mipsAluPkg::functSllv, 5'd0), 32'h0000_0024, 32'h0000_0001); // 36 -> 4
        addVec(rOp(mipsAluPkg::functSrlv, 5'd0), 32'hffff_ffe1, 32'h8000_0000);
        addVec(rOp(mipsAluPkg::functSrav, 5'd0), 32'h0000_003f, 32'h8000_0010);
        addVec(rOp(mipsAluPkg::functSlt, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        addVec(rOp(mipsAluPkg::functSltu, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        addVec(iOp(mipsAluPkg::opcodeSlti, 16'hffff), 32'h0000_0005, $urandom);
        addVec(iOp(mipsAluPkg::opcodeSltiu, 16'hffff), 32'h0000_0005, $urandom);
        addVec(rOp(mipsAluPkg::functMult, 5'd0), 32'hffff_fffd, 32'h0000_0007);
        addVec(rOp(mipsAluPkg::functMfhi, 5'd0), $urandom, $urandom); // right after mult
        addVec(rOp(mipsAluPkg::functMflo, 5'd0), $urandom, $urandom);
        addVec(rOp(mipsAluPkg::functMultu, 5'd0), 32'hffff_ffff, 32'h0000_0002);
        addVec(rOp(mipsAluPkg::functMfhi, 5'd0), $urandom, $urandom);
        addVec(rOp(mipsAluPkg::functDiv, 5'd0), 32'hffff_fff9, 32'h0000_0002);
        addVec(rOp(mipsAluPkg::functMfhi, 5'd0), $urandom, $urandom);
        addVec(rOp(mipsAluPkg::functMflo, 5'd0), $urandom, $urandom);
        addVec(rOp(mipsAluPkg::functDiv, 5'd0), 32'h0000_0005, 32'h0000_0000);
        addVec(rOp(mipsAluPkg::functMfhi, 5'd0), $urandom, $urandom);
        addVec(rOp(mipsAluPkg::functDivu, 5'd0), 32'hffff_ffff, 32'h0000_000a);
        addVec(rOp(mipsAluPkg::functDivu, 5'd0), 32'h0000_0007, 32'h0000_0000);
        addVec(rOp(mipsAluPkg::functMflo, 5'd0), $urandom, $urandom);
        addVec(iOp(6'h3f, 16'h1234), $urandom, $urandom); // unknown opcode
        addVec(rOp(6'h01, 5'd0), $urandom, $urandom);     // unknown funct
        addVec(rOp(mipsAluPkg::functMfhi, 5'd0), $urandom, $urandom);
        for (int k = 0; k < 12; k++) begin
            idx = int'($urandom % 6);
            addVec(rOp(randFuncts[idx], 5'($urandom % 32)), $urandom, $urandom);
        end
    endtask

    // ########################################
    // compare tasks
    task automatic checkResult(input mipsAluPkg::execResultT exp);
        if (result.valid !== exp.valid) begin
            $display("Fail time=%0t result.valid exp=%b got=%b", $time, exp.valid, result.valid);
            errors++;
        end
        if (result.illegal !== exp.illegal) begin
            $display("Fail time=%0t result.illegal exp=%b got=%b", $time, exp.illegal,
                result.illegal);
            errors++;
        end
        if (exp.valid && result.data !== exp.data) begin // data only matters with valid
            $display("Fail time=%0t result.data exp=%h got=%h", $time, exp.data, result.data);
            errors++;
        end
    endtask

    task automatic checkHiLo(input mipsAluPkg::hiLoT exp);
        if (hiLo !== exp) begin
            $display("Fail time=%0t hiLo exp=%h got=%h", $time, exp, hiLo);
            errors++;
        end
    endtask

    initial begin : watchdog
        wait (tableReady);
        repeat (vectors.size() + 20) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", vectors.size() + 20);
        $display("tests failed");
        $finish;
    end

    initial begin
        int                     n;
        mipsAluPkg::execResultT idle;
        errors = 0;
        tableReady = 1'b0;
        idle = '0;
        void'($urandom(32'h28f5ee32));
        rstN = 1'b0;
        issue = 1'b0;
        instr = '0;
        rsData = '0;
        rtData = '0;
        buildTable();
        n = vectors.size();
        tableReady = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // entry i is driven at negedge i and checked two negedges later
        for (int i = 0; i < n + 3; i++) begin
            @(negedge clk);
            if (i >= 2 && i - 2 < n) begin
                checkResult(vectors[i-2].expResult);
                checkHiLo(vectors[i-2].expHiLo);
            end else begin
                checkResult(idle);
                if (i < 2) begin
                    checkHiLo('0);
                end else begin
                    checkHiLo(vectors[n-1].expHiLo);
                end
            end
            if (i < n) begin
                issue  = 1'b1;
                instr  = vectors[i].instr;
                rsData = vectors[i].rs;
                rtData = vectors[i].rt;
            end else begin
                issue = 1'b0;
            end
        end
        $display("%0d vectors run, %0d errors", n, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
mipsAluPkg.sv
instrDecoder.sv
intAlu.sv
mulDivUnit.sv
mipsExecute.sv
mipsExecuteTb.sv

// ==== Makefile ====
SOURCES := $(shell cat project.f)

all: run

obj_dir/VmipsExecuteTb: project.f $(SOURCES)
	verilator --binary --timing --assert -f project.f --top-module mipsExecuteTb -Mdir obj_dir

run: obj_dir/VmipsExecuteTb
	./obj_dir/VmipsExecuteTb | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
